// ==== hdl/frontend_settings.svh ====
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// instruction queue entries
// keep a power of two as the pointers wrap on their own width
`define FE_IQ_DEPTH 8

// filler for slots that do not issue
// andi r0, r0, 0
`define FE_INST_NOP 32'h0340_0000

// stage register pc out of reset
`define FE_PC_RESET 32'h1c00_0000

`endif

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // program counter
    typedef logic [31:0] pc_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // exception code where zero means none
    typedef logic [6:0] excp_t;

    localparam excp_t EXCP_NONE = 7'd0;

    // one queue entry
    // excp and badv only meaningful on the first slot of a response
    typedef struct packed {
        pc_t         pc;
        inst_t       inst;
        excp_t       excp;
        logic [31:0] badv;
    } iq_entry_t;

endpackage

// ==== hdl/serial_pkg.sv ====
package serial_pkg;

    // serializing instruction class flagged by the pre-decoder
    typedef enum logic [1:0] {
        kind_none,
        kind_ibar,
        kind_csr,
        kind_tlb
    } serial_kind_t;

    // controller states
    // wait_ex states wait for the instruction to reach execute
    typedef enum logic [2:0] {
        st_idle,
        st_wait_ex_ibar,
        st_wait_ex_csr,
        st_wait_ex_tlb,
        st_wait_cache_idle,
        st_wait_csr_done,
        st_wait_tlb_done
    } serial_state_t;

endpackage

// ==== hdl/fetch_align.sv ====
`include "frontend_settings.svh"

module fetch_align (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush,
    input  logic                     resp_valid,
    output logic                     resp_ready,
    input  fetch_pkg::pc_t           resp_pc,
    input  fetch_pkg::inst_t         resp_inst0,
    input  fetch_pkg::inst_t         resp_inst1,
    input  fetch_pkg::excp_t         resp_excp,
    input  logic [31:0]              resp_badv,
    input  serial_pkg::serial_kind_t resp_serial0,
    input  serial_pkg::serial_kind_t resp_serial1,
    input  logic                     fetch_hold,
    output logic                     pair_valid,
    input  logic                     pair_ready,
    output logic [1:0]               pair_cnt,
    output fetch_pkg::iq_entry_t     pair_e0,
    output fetch_pkg::iq_entry_t     pair_e1,
    output logic                     ser_valid,
    output serial_pkg::serial_kind_t ser_kind,
    output fetch_pkg::pc_t           ser_pc
);

    fetch_pkg::iq_entry_t     slot0;
    fetch_pkg::iq_entry_t     slot1;
    logic [1:0]               slot_cnt;
    logic                     two_slots;
    fetch_pkg::pc_t           next_pc;
    serial_pkg::serial_kind_t first_kind;
    serial_pkg::serial_kind_t last_kind;

    logic                     accept;
    logic                     stg_free;
    logic                     hold_q;

    logic                     stg_valid;
    logic [1:0]               stg_cnt;
    fetch_pkg::iq_entry_t     stg_e0;
    fetch_pkg::iq_entry_t     stg_e1;

    logic                     skid_valid;
    logic [1:0]               skid_cnt;
    fetch_pkg::iq_entry_t     skid_e0;
    fetch_pkg::iq_entry_t     skid_e1;

    // slot selection for the current response
    always_comb begin
        next_pc    = resp_pc + 32'd4;
        first_kind = resp_pc[2] ? resp_serial1 : resp_serial0;
        // second slot only for an even pc with a clean first slot
        two_slots  = !resp_pc[2]
                     && (resp_excp == fetch_pkg::EXCP_NONE)
                     && (resp_serial0 == serial_pkg::kind_none);

        slot0 = '{pc: resp_pc, inst: resp_pc[2] ? resp_inst1 : resp_inst0,
                  excp: resp_excp, badv: resp_badv};
        slot1 = '{pc: next_pc, inst: `FE_INST_NOP,
                  excp: fetch_pkg::EXCP_NONE, badv: 32'd0};

        slot_cnt  = 2'd1;
        last_kind = first_kind;
        ser_pc    = resp_pc;
        if (two_slots) begin
            slot1.inst = resp_inst1;
            slot_cnt   = 2'd2;
            last_kind  = resp_serial1;
            ser_pc     = next_pc;
        end
    end

    // hold is taken one cycle late here
    // the accept cycle's own hold term would otherwise loop back into resp_ready
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            hold_q <= 1'b0;
        end else begin
            hold_q <= fetch_hold;
        end
    end

    assign resp_ready = !skid_valid && !hold_q && !flush;
    assign accept     = resp_valid && resp_ready;
    assign ser_valid  = accept && (last_kind != serial_pkg::kind_none);
    assign ser_kind   = last_kind;

    // stage can take new data when empty or draining this cycle
    assign stg_free = !stg_valid || pair_ready;

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            stg_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (stg_free) begin
            stg_valid  <= skid_valid || accept;
            skid_valid <= 1'b0;
        end else if (accept) begin
            skid_valid <= 1'b1;
        end
    end

    // stage payload with the older skid entry taking priority
    always_ff @(posedge clk) begin
        if (!rstn) begin
            stg_cnt <= 2'd0;
            stg_e0  <= '{pc: `FE_PC_RESET, inst: `FE_INST_NOP,
                         excp: fetch_pkg::EXCP_NONE, badv: 32'd0};
            stg_e1  <= '{pc: `FE_PC_RESET + 32'd4, inst: `FE_INST_NOP,
                         excp: fetch_pkg::EXCP_NONE, badv: 32'd0};
        end else if (stg_free && skid_valid) begin
            stg_cnt <= skid_cnt;
            stg_e0  <= skid_e0;
            stg_e1  <= skid_e1;
        end else if (stg_free && accept) begin
            stg_cnt <= slot_cnt;
            stg_e0  <= slot0;
            stg_e1  <= slot1;
        end
    end

    // skid catches the response accepted while the stage is stuck
    always_ff @(posedge clk) begin
        if (accept && !stg_free) begin
            skid_cnt <= slot_cnt;
            skid_e0  <= slot0;
            skid_e1  <= slot1;
        end
    end

    assign pair_valid = stg_valid;
    assign pair_cnt   = stg_cnt;
    assign pair_e0    = stg_e0;
    assign pair_e1    = stg_e1;

    // offered pair stays put until the queue takes it
    pair_stable_a: assert property (@(posedge clk) disable iff (!rstn)
        pair_valid && !pair_ready && !flush |=> pair_valid && $stable(pair_e0)
                                                && $stable(pair_e1)
                                                && $stable(pair_cnt));

endmodule

// ==== hdl/inst_queue.sv ====
`include "frontend_settings.svh"

module inst_queue (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 flush,
    input  logic                 pair_valid,
    output logic                 pair_ready,
    input  logic [1:0]           pair_cnt,
    input  fetch_pkg::iq_entry_t pair_e0,
    input  fetch_pkg::iq_entry_t pair_e1,
    output logic                 out_valid,
    input  logic                 out_ready,
    output fetch_pkg::iq_entry_t out_entry
);

    localparam int DEPTH = `FE_IQ_DEPTH;
    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL = (AW + 1)'(DEPTH);

    fetch_pkg::iq_entry_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [AW:0]   count_next;
    logic [AW:0]   free;
    logic          wr_en;
    logic          rd_en;

    // room for a full pair is required whatever its size
    assign free       = FULL - count;
    assign pair_ready = free >= (AW + 1)'(2);
    assign wr_en      = pair_valid && pair_ready;

    assign out_valid  = count != '0;
    assign out_entry  = mem[rd_ptr];
    assign rd_en      = out_valid && out_ready;

    always_comb begin
        count_next = count;
        if (wr_en) begin
            count_next = count_next + (AW + 1)'(pair_cnt);
        end
        if (rd_en) begin
            count_next = count_next - (AW + 1)'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + AW'(pair_cnt);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            count <= count_next;
        end
    end

    // second entry lands right behind the first and wraps
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= pair_e0;
            if (pair_cnt == 2'd2) begin
                mem[wr_ptr + AW'(1)] <= pair_e1;
            end
        end
    end

    count_bound_a: assert property (@(posedge clk) disable iff (!rstn)
        count <= FULL);

    // a write only happens when every entry of the pair fits
    write_room_a: assert property (@(posedge clk) disable iff (!rstn)
        wr_en |-> (count + (AW + 1)'(pair_cnt)) <= FULL);

    // aligner only ever offers one or two slots
    pair_cnt_a: assert property (@(posedge clk) disable iff (!rstn)
        pair_valid |-> (pair_cnt == 2'd1) || (pair_cnt == 2'd2));

endmodule

// ==== hdl/serial_ctrl.sv ====
module serial_ctrl (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush,
    input  logic                     ser_valid,
    input  serial_pkg::serial_kind_t ser_kind,
    input  fetch_pkg::pc_t           ser_pc,
    input  logic                     ex_serial_hit,
    input  logic                     cache_idle,
    input  logic                     csr_done,
    input  logic                     tlb_done,
    output logic                     fetch_hold,
    output logic                     redirect_valid,
    output fetch_pkg::pc_t           redirect_pc
);

    serial_pkg::serial_state_t state_q;
    serial_pkg::serial_state_t state_d;
    fetch_pkg::pc_t            saved_pc;
    logic                      redirect_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            serial_pkg::st_idle: begin
                if (ser_valid) begin
                    case (ser_kind)
                        serial_pkg::kind_ibar: state_d = serial_pkg::st_wait_ex_ibar;
                        serial_pkg::kind_csr:  state_d = serial_pkg::st_wait_ex_csr;
                        serial_pkg::kind_tlb:  state_d = serial_pkg::st_wait_ex_tlb;
                        default:               state_d = serial_pkg::st_idle;
                    endcase
                end
            end
            // instruction still on its way to execute
            serial_pkg::st_wait_ex_ibar: begin
                if (ex_serial_hit) begin
                    state_d = serial_pkg::st_wait_cache_idle;
                end
            end
            serial_pkg::st_wait_ex_csr: begin
                if (ex_serial_hit) begin
                    state_d = serial_pkg::st_wait_csr_done;
                end
            end
            serial_pkg::st_wait_ex_tlb: begin
                if (ex_serial_hit) begin
                    state_d = serial_pkg::st_wait_tlb_done;
                end
            end
            // each kind only listens to its own completion
            serial_pkg::st_wait_cache_idle: begin
                if (cache_idle) begin
                    state_d = serial_pkg::st_idle;
                end
            end
            serial_pkg::st_wait_csr_done: begin
                if (csr_done) begin
                    state_d = serial_pkg::st_idle;
                end
            end
            serial_pkg::st_wait_tlb_done: begin
                if (tlb_done) begin
                    state_d = serial_pkg::st_idle;
                end
            end
            default: begin
                state_d = serial_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            state_q <= serial_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // one pulse right after the return to idle
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= (state_q != serial_pkg::st_idle)
                          && (state_d == serial_pkg::st_idle);
        end
    end

    always_ff @(posedge clk) begin
        if (ser_valid && (state_q == serial_pkg::st_idle)) begin
            saved_pc <= ser_pc;
        end
    end

    // ser_valid term stops the pc generator in the accept cycle itself
    assign fetch_hold     = (state_q != serial_pkg::st_idle) || ser_valid;
    assign redirect_valid = redirect_q;
    assign redirect_pc    = saved_pc + 32'd4;

    redirect_pulse_a: assert property (@(posedge clk) disable iff (!rstn)
        redirect_valid |=> !redirect_valid);

endmodule

// ==== hdl/frontend_top.sv ====
module frontend_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush,
    // cache response
    input  logic                     resp_valid,
    output logic                     resp_ready,
    input  fetch_pkg::pc_t           resp_pc,
    input  fetch_pkg::inst_t         resp_inst0,
    input  fetch_pkg::inst_t         resp_inst1,
    input  fetch_pkg::excp_t         resp_excp,
    input  logic [31:0]              resp_badv,
    input  serial_pkg::serial_kind_t resp_serial0,
    input  serial_pkg::serial_kind_t resp_serial1,
    // decode side
    output logic                     out_valid,
    input  logic                     out_ready,
    output fetch_pkg::iq_entry_t     out_entry,
    // back end events
    input  logic                     ex_serial_hit,
    input  logic                     cache_idle,
    input  logic                     csr_done,
    input  logic                     tlb_done,
    output logic                     fetch_hold,
    output logic                     redirect_valid,
    output fetch_pkg::pc_t           redirect_pc
);

    logic                     pair_valid;
    logic                     pair_ready;
    logic [1:0]               pair_cnt;
    fetch_pkg::iq_entry_t     pair_e0;
    fetch_pkg::iq_entry_t     pair_e1;
    logic                     ser_valid;
    serial_pkg::serial_kind_t ser_kind;
    fetch_pkg::pc_t           ser_pc;

    fetch_align align_i (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_pc      (resp_pc),
        .resp_inst0   (resp_inst0),
        .resp_inst1   (resp_inst1),
        .resp_excp    (resp_excp),
        .resp_badv    (resp_badv),
        .resp_serial0 (resp_serial0),
        .resp_serial1 (resp_serial1),
        .fetch_hold   (fetch_hold),
        .pair_valid   (pair_valid),
        .pair_ready   (pair_ready),
        .pair_cnt     (pair_cnt),
        .pair_e0      (pair_e0),
        .pair_e1      (pair_e1),
        .ser_valid    (ser_valid),
        .ser_kind     (ser_kind),
        .ser_pc       (ser_pc)
    );

    inst_queue queue_i (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .pair_valid (pair_valid),
        .pair_ready (pair_ready),
        .pair_cnt   (pair_cnt),
        .pair_e0    (pair_e0),
        .pair_e1    (pair_e1),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_entry  (out_entry)
    );

    serial_ctrl serial_i (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .ser_valid      (ser_valid),
        .ser_kind       (ser_kind),
        .ser_pc         (ser_pc),
        .ex_serial_hit  (ex_serial_hit),
        .cache_idle     (cache_idle),
        .csr_done       (csr_done),
        .tlb_done       (tlb_done),
        .fetch_hold     (fetch_hold),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// ==== verification/frontend_tb.sv ====
module frontend_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_rows = 20;
    localparam serial_pkg::serial_kind_t k_none = serial_pkg::kind_none;
    localparam serial_pkg::serial_kind_t k_ibar = serial_pkg::kind_ibar;
    localparam serial_pkg::serial_kind_t k_csr  = serial_pkg::kind_csr;
    localparam serial_pkg::serial_kind_t k_tlb  = serial_pkg::kind_tlb;

    // one cache response plus the back-end events that go with it
    typedef struct packed {
        fetch_pkg::pc_t           pc;
        fetch_pkg::inst_t         inst0;
        fetch_pkg::inst_t         inst1;
        fetch_pkg::excp_t         excp;
        logic [31:0]              badv;
        serial_pkg::serial_kind_t ser0;
        serial_pkg::serial_kind_t ser1;
        logic                     noise;
        logic                     do_flush;
    } row_t;

    logic                     clk;
    logic                     rstn;
    logic                     flush;
    logic                     resp_valid;
    logic                     resp_ready;
    fetch_pkg::pc_t           resp_pc;
    fetch_pkg::inst_t         resp_inst0;
    fetch_pkg::inst_t         resp_inst1;
    fetch_pkg::excp_t         resp_excp;
    logic [31:0]              resp_badv;
    serial_pkg::serial_kind_t resp_serial0;
    serial_pkg::serial_kind_t resp_serial1;
    logic                     out_valid;
    logic                     out_ready;
    fetch_pkg::iq_entry_t     out_entry;
    logic                     ex_serial_hit;
    logic                     cache_idle;
    logic                     csr_done;
    logic                     tlb_done;
    logic                     fetch_hold;
    logic                     redirect_valid;
    fetch_pkg::pc_t           redirect_pc;

    row_t                     rows [n_rows];
    fetch_pkg::iq_entry_t     exp_q [$];
    fetch_pkg::pc_t           exp_redirect;
    logic                     redirect_pending;
    logic                     drain_en;
    int                       stall_cycles;

    frontend_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_entry(input string name, input fetch_pkg::iq_entry_t got,
                               input fetch_pkg::iq_entry_t exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH time %0t signal %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_redirect(input fetch_pkg::pc_t got, input fetch_pkg::pc_t exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH time %0t signal redirect_pc got %h expected %h",
                               $time, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH time %0t signal %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // one cycle in which fetch must stay blocked
    task automatic held_cycle();
        @(negedge clk);
        check_flag("resp_ready", resp_ready, 1'b0);
        check_flag("fetch_hold", fetch_hold, 1'b1);
        next_cycle();
    endtask

    task automatic drive_conditions(input serial_pkg::serial_kind_t kind, input logic own,
                                    input logic other);
        cache_idle = (kind == k_ibar) ? own : other;
        csr_done   = (kind == k_csr) ? own : other;
        tlb_done   = (kind == k_tlb) ? own : other;
    endtask

    function automatic row_t make_row(input fetch_pkg::pc_t pc, input fetch_pkg::excp_t excp,
                                      input serial_pkg::serial_kind_t s0,
                                      input serial_pkg::serial_kind_t s1,
                                      input logic noise, input logic do_flush);
        row_t r;
        r.pc       = pc;
        r.inst0    = pc ^ 32'h0280_0001;
        r.inst1    = pc ^ 32'h0380_0002;
        r.excp     = excp;
        r.badv     = pc ^ 32'h8000_0000;
        r.ser0     = s0;
        r.ser1     = s1;
        r.noise    = noise;
        r.do_flush = do_flush;
        return r;
    endfunction

    // reference slot rules push what decode should see
    task automatic expand_row(input row_t r, output serial_pkg::serial_kind_t kind,
                              output fetch_pkg::pc_t spc);
        fetch_pkg::iq_entry_t first;
        fetch_pkg::iq_entry_t second;
        first.pc   = r.pc;
        first.inst = r.pc[2] ? r.inst1 : r.inst0;
        first.excp = r.excp;
        first.badv = r.badv;
        kind       = r.pc[2] ? r.ser1 : r.ser0;
        spc        = r.pc;
        exp_q.push_back(first);
        if (!r.pc[2] && r.excp == 7'd0 && kind == k_none) begin
            second.pc   = r.pc + 32'd4;
            second.inst = r.inst1;
            second.excp = 7'd0;
            second.badv = 32'd0;
            exp_q.push_back(second);
            kind = r.ser1;
            spc  = second.pc;
        end
    endtask

    task automatic send_row(input row_t r);
        logic taken;
        taken        = 1'b0;
        resp_valid   = 1'b1;
        resp_pc      = r.pc;
        resp_inst0   = r.inst0;
        resp_inst1   = r.inst1;
        resp_excp    = r.excp;
        resp_badv    = r.badv;
        resp_serial0 = r.ser0;
        resp_serial1 = r.ser1;
        while (!taken) begin
            @(negedge clk);
            taken = resp_ready;
            if (!resp_ready)
                stall_cycles++;
            next_cycle();
        end
        resp_valid = 1'b0;
    endtask

    task automatic run_serial(input row_t r, input serial_pkg::serial_kind_t kind,
                              input fetch_pkg::pc_t spc);
        if (r.do_flush) begin
            // serializing entry must sit in the queue when flush hits
            while (!(out_valid && !dut_i.pair_valid))
                held_cycle();
            flush = 1'b1;
            exp_q.delete();
            next_cycle();
            flush = 1'b0;
            repeat (10) begin
                @(negedge clk);
                check_flag("out_valid", out_valid, 1'b0);
                check_flag("fetch_hold", fetch_hold, 1'b0);
                next_cycle();
            end
            drain_en = 1'b1;
        end else begin
            // execute only sees it once decode has taken it
            while (exp_q.size() != 0)
                held_cycle();
            if (r.noise) begin
                drive_conditions(kind, 1'b1, 1'b1);
                held_cycle();
                drive_conditions(kind, 1'b0, 1'b0);
            end
            ex_serial_hit = 1'b1;
            held_cycle();
            ex_serial_hit = 1'b0;
            if (r.noise) begin
                drive_conditions(kind, 1'b0, 1'b1);
                held_cycle();
                drive_conditions(kind, 1'b0, 1'b0);
            end
            exp_redirect     = spc + 32'd4;
            redirect_pending = 1'b1;
            drive_conditions(kind, 1'b1, 1'b0);
            held_cycle();
            drive_conditions(kind, 1'b0, 1'b0);
            while (redirect_pending)
                next_cycle();
        end
    endtask

    // decode side with random out_ready and in-order compare
    initial begin
        fetch_pkg::iq_entry_t expected;
        logic                 ready_next;
        void'($urandom(32'h48f4_6156));
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (rstn && !flush && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    fail_now("decode received an entry that was never expected");
                end else begin
                    expected = exp_q.pop_front();
                    check_entry("out_entry", out_entry, expected);
                end
            end
            ready_next = (($urandom % 3) == 0) && rstn && drain_en;
            next_cycle();
            out_ready = ready_next;
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (rstn && redirect_valid) begin
                if (!redirect_pending) begin
                    fail_now("redirect seen without a completed serialization");
                end else begin
                    check_redirect(redirect_pc, exp_redirect);
                    redirect_pending = 1'b0;
                end
            end
        end
    end

    initial begin
        repeat (200 * n_rows) @(posedge clk);
        fail_now("watchdog expired before all table rows finished");
    end

    initial begin
        row_t                     r;
        serial_pkg::serial_kind_t kind;
        fetch_pkg::pc_t           spc;
        rstn             = 1'b0;
        flush            = 1'b0;
        resp_valid       = 1'b0;
        resp_pc          = 32'd0;
        resp_inst0       = 32'd0;
        resp_inst1       = 32'd0;
        resp_excp        = 7'd0;
        resp_badv        = 32'd0;
        resp_serial0     = k_none;
        resp_serial1     = k_none;
        ex_serial_hit    = 1'b0;
        cache_idle       = 1'b0;
        csr_done         = 1'b0;
        tlb_done         = 1'b0;
        exp_redirect     = 32'd0;
        redirect_pending = 1'b0;
        drain_en         = 1'b1;
        stall_cycles     = 0;

        // pc, excp, serial0, serial1, noise, flush
        rows[0]  = make_row(32'h1c00_0000, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[1]  = make_row(32'h1c00_000c, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[2]  = make_row(32'h1c00_0010, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[3]  = make_row(32'h1c00_0018, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[4]  = make_row(32'h1c00_0024, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[5]  = make_row(32'h1c00_0028, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[6]  = make_row(32'h1c00_0030, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[7]  = make_row(32'h1c00_0038, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[8]  = make_row(32'h1c00_0040, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[9]  = make_row(32'h1c00_0048, 7'h08, k_none, k_none, 1'b0, 1'b0);
        rows[10] = make_row(32'h1c00_0054, 7'h0a, k_none, k_none, 1'b0, 1'b0);
        rows[11] = make_row(32'h1c00_0060, 7'h00, k_ibar, k_tlb, 1'b0, 1'b0);
        rows[12] = make_row(32'h1c00_0064, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[13] = make_row(32'h1c00_0070, 7'h00, k_none, k_csr, 1'b1, 1'b0);
        rows[14] = make_row(32'h1c00_007c, 7'h00, k_none, k_tlb, 1'b1, 1'b0);
        rows[15] = make_row(32'h1c00_0080, 7'h00, k_ibar, k_none, 1'b1, 1'b0);
        rows[16] = make_row(32'h1c00_0090, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[17] = make_row(32'h1c00_0098, 7'h00, k_csr, k_none, 1'b0, 1'b1);
        rows[18] = make_row(32'h1c00_00a0, 7'h00, k_none, k_none, 1'b0, 1'b0);
        rows[19] = make_row(32'h1c00_00ac, 7'h00, k_none, k_none, 1'b0, 1'b0);

        repeat (5) @(posedge clk);
        #10;
        rstn = 1'b1;
        @(negedge clk);
        check_flag("resp_ready", resp_ready, 1'b1);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("pair_valid", dut_i.pair_valid, 1'b0);
        check_flag("fetch_hold", fetch_hold, 1'b0);
        check_flag("redirect_valid", redirect_valid, 1'b0);
        next_cycle();

        for (int i = 0; i < n_rows; i++) begin
            r = rows[i];
            // decode stalls so the flushed queue still holds entries
            if (r.do_flush)
                drain_en = 1'b0;
            expand_row(r, kind, spc);
            send_row(r);
            if (kind != k_none)
                run_serial(r, kind, spc);
        end
        while (exp_q.size() != 0)
            next_cycle();
        repeat (4) next_cycle();

        // nothing may be left over once every expected entry came out
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);

        if (stall_cycles == 0) begin
            fail_now("queue back-pressure never held off the cache");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/serial_pkg.sv
hdl/fetch_align.sv
hdl/inst_queue.sv
hdl/serial_ctrl.sv
hdl/frontend_top.sv
verification/frontend_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := frontend_tb
FILELIST   := compile.f
COMMON     := --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
